/* src/mmu_defs.svh */
// mmu sizing: TLB depth and the address field widths shared by all MMU blocks
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// tlb geometry
`define MMU_TLB_NUM 16
`define MMU_IDX_W   4   // log2 of MMU_TLB_NUM

// virtual page pair number, vaddr[31:13]
// bit 12 picks the odd or even half of the pair
`define MMU_VPPN_W  19

// physical page number of a 4 KB page, paddr[31:12]
`define MMU_PPN_W   20

// address space id from the asid CSR
`define MMU_ASID_W  10

// direct-mapping window segment, vaddr[31:29] and paddr[31:29]
`define MMU_VSEG_W  3

`endif

/* src/mmu_pkg.sv */
// mmu types: request kinds, exception codes, TLB entries and the port structs
`include "mmu_defs.svh"

package mmu_pkg;

   typedef enum logic [1:0] {
      op_none,
      op_tlbsrch,
      op_load,
      op_store
   } mem_op_e;

   // one code per result, ordered as the exception priority
   typedef enum logic [2:0] {
      exc_none,
      exc_adem,
      exc_tlbr,
      exc_pil,
      exc_pis,
      exc_ppi,
      exc_pme
   } exc_e;

   typedef enum logic [1:0] {
      cmd_none,
      cmd_wr,
      cmd_fill
   } tlb_cmd_e;

   // one 4 KB half of a page pair
   typedef struct packed {
      logic                  valid;
      logic                  dirty;
      logic [1:0]            plv;
      logic [1:0]            mat;   // 0 means strongly ordered uncached
      logic [`MMU_PPN_W-1:0] ppn;
   } tlb_lo_t;

   typedef struct packed {
      logic                   exists;
      logic [`MMU_VPPN_W-1:0] vppn;
      logic [`MMU_ASID_W-1:0] asid;
      logic                   g;     // global, matches any asid
      tlb_lo_t                lo0;
      tlb_lo_t                lo1;
   } tlb_entry_t;

   typedef struct packed {
      logic                   plv0;
      logic                   plv3;
      logic [1:0]             mat;
      logic [`MMU_VSEG_W-1:0] pseg;
      logic [`MMU_VSEG_W-1:0] vseg;
   } dmw_t;

   // decoded fields of crmd, asid, tlbehi, tlbidx, tlbelo0/1, dmw0/1
   typedef struct packed {
      logic                   da;
      logic [1:0]             plv;
      logic [1:0]             datm;
      logic [`MMU_ASID_W-1:0] asid;
      logic [`MMU_VPPN_W-1:0] tlbehi_vppn;
      logic [`MMU_IDX_W-1:0]  tlbidx;
      logic                   ne;
      tlb_lo_t                elo0;
      logic                   elo0_g;
      tlb_lo_t                elo1;
      logic                   elo1_g;
      dmw_t                   dmw0;
      dmw_t                   dmw1;
   } csr_view_t;

   typedef struct packed {
      logic        valid;
      mem_op_e     op;
      logic [31:0] vaddr;
   } xlate_req_t;

   typedef struct packed {
      logic                  valid;
      logic [31:0]           paddr;
      logic                  uncached;
      exc_e                  exc;
      logic                  found;
      logic [`MMU_IDX_W-1:0] index;
   } xlate_rsp_t;

   typedef struct packed {
      logic [`MMU_VPPN_W-1:0] vppn;
      logic                   odd;
      logic [`MMU_ASID_W-1:0] asid;
   } srch_req_t;

   typedef struct packed {
      logic                  found;
      logic [`MMU_IDX_W-1:0] index;
      tlb_lo_t               lo;
   } srch_rsp_t;

   typedef struct packed {
      logic       valid;
      tlb_entry_t entry;
   } tlb_rd_rsp_t;

endpackage

/* src/tlb_array.sv */
// tlb array: fully associative entry store with one search, one write and one read port
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_array import mmu_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   // search port, answered in the same cycle
   input  srch_req_t             srch_i,
   output srch_rsp_t             srch_o,
   // write port
   input  logic                  wr_en_i,
   input  logic [`MMU_IDX_W-1:0] wr_idx_i,
   input  tlb_entry_t            wr_entry_i,
   // read port
   input  logic [`MMU_IDX_W-1:0] rd_idx_i,
   output tlb_entry_t            rd_entry_o
);

   tlb_entry_t              tlb_q [`MMU_TLB_NUM];
   logic [`MMU_TLB_NUM-1:0] hit;
   logic                    hit_any;
   logic [`MMU_IDX_W-1:0]   hit_idx;
   tlb_entry_t              hit_entry;

   // reset invalidates every slot
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `MMU_TLB_NUM; i++) begin
            tlb_q[i].exists <= 1'b0;
         end
      end else if (wr_en_i) begin
         tlb_q[wr_idx_i] <= wr_entry_i;
      end
   end

   // parallel compare of all slots
   always_comb begin
      for (int i = 0; i < `MMU_TLB_NUM; i++) begin
         hit[i] = tlb_q[i].exists
                  && (tlb_q[i].vppn == srch_i.vppn)
                  && (tlb_q[i].g || (tlb_q[i].asid == srch_i.asid));
      end
   end

   assign hit_any = |hit;

   // lowest matching slot wins
   always_comb begin
      hit_idx = '0;
      for (int i = `MMU_TLB_NUM - 1; i >= 0; i--) begin
         if (hit[i]) begin
            hit_idx = i[`MMU_IDX_W-1:0];
         end
      end
   end

   assign hit_entry = tlb_q[hit_idx];

   always_comb begin
      srch_o.found = hit_any;
      srch_o.index = hit_idx;
      srch_o.lo    = srch_i.odd ? hit_entry.lo1 : hit_entry.lo0;   // vaddr[12] picks the half
   end

   assign rd_entry_o = tlb_q[rd_idx_i];

endmodule

/* src/addr_xlate.sv */
// address translation stage: direct, window or paged mapping with exception resolution
`timescale 1ns/1ps
`include "mmu_defs.svh"

module addr_xlate import mmu_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  csr_view_t  csr_i,
   input  xlate_req_t req_i,
   output srch_req_t  srch_o,
   input  srch_rsp_t  srch_i,
   output xlate_rsp_t rsp_o
);

   logic       is_srch;
   logic       is_load;
   logic       is_store;
   logic       dmw0_hit;
   logic       dmw1_hit;
   logic       mapped;
   xlate_rsp_t rsp_d;
   xlate_rsp_t rsp_q;

   // window enabled for the current privilege level and segment equal
   function automatic logic win_hit(input dmw_t w, input logic [1:0] plv,
                                    input logic [31:0] va);
      logic plv_ok;
      plv_ok = (w.plv0 && (plv == 2'd0)) || (w.plv3 && (plv == 2'd3));
      return plv_ok && (w.vseg == va[31:32-`MMU_VSEG_W]);
   endfunction

   assign is_srch  = (req_i.op == op_tlbsrch);
   assign is_load  = (req_i.op == op_load);
   assign is_store = (req_i.op == op_store);

   assign dmw0_hit = win_hit(csr_i.dmw0, csr_i.plv, req_i.vaddr);
   assign dmw1_hit = win_hit(csr_i.dmw1, csr_i.plv, req_i.vaddr);
   assign mapped   = !csr_i.da && !dmw0_hit && !dmw1_hit;

   // tlbsrch looks up the tlbehi page, loads and stores their own vaddr
   always_comb begin
      srch_o.asid = csr_i.asid;
      if (is_srch) begin
         srch_o.vppn = csr_i.tlbehi_vppn;
         srch_o.odd  = 1'b0;
      end else begin
         srch_o.vppn = req_i.vaddr[31:13];
         srch_o.odd  = req_i.vaddr[12];
      end
   end

   always_comb begin
      rsp_d       = '0;
      rsp_d.valid = req_i.valid;
      rsp_d.found = srch_i.found;
      rsp_d.index = srch_i.found ? srch_i.index : '0;

      // physical address and memory type
      if (csr_i.da) begin
         rsp_d.paddr    = req_i.vaddr;
         rsp_d.uncached = (csr_i.datm == 2'd0);
      end else if (dmw0_hit) begin                     // dmw0 has precedence
         rsp_d.paddr    = {csr_i.dmw0.pseg, req_i.vaddr[31-`MMU_VSEG_W:0]};
         rsp_d.uncached = (csr_i.dmw0.mat == 2'd0);
      end else if (dmw1_hit) begin
         rsp_d.paddr    = {csr_i.dmw1.pseg, req_i.vaddr[31-`MMU_VSEG_W:0]};
         rsp_d.uncached = (csr_i.dmw1.mat == 2'd0);
      end else begin
         rsp_d.paddr    = {srch_i.lo.ppn, req_i.vaddr[11:0]};
         rsp_d.uncached = (srch_i.lo.mat == 2'd0);
      end

      // only paged loads and stores can fault, first match wins
      rsp_d.exc = exc_none;
      if (mapped && (is_load || is_store)) begin
         if ((csr_i.plv == 2'd3) && req_i.vaddr[31])
            rsp_d.exc = exc_adem;                      // user access to kernel half
         else if (!srch_i.found)
            rsp_d.exc = exc_tlbr;
         else if (is_load && !srch_i.lo.valid)
            rsp_d.exc = exc_pil;
         else if (is_store && !srch_i.lo.valid)
            rsp_d.exc = exc_pis;
         else if (csr_i.plv > srch_i.lo.plv)
            rsp_d.exc = exc_ppi;
         else if (is_store && !srch_i.lo.dirty)
            rsp_d.exc = exc_pme;                       // first write to a clean page
      end
   end

   // result register, one request per cycle and no stall
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_q.valid <= 1'b0;
      end else begin
         rsp_q <= rsp_d;
      end
   end

   assign rsp_o = rsp_q;

endmodule

/* src/tlb_maint.sv */
// tlb maintenance: entry build for tlbwr and tlbfill, refill slot counter, tlbrd return
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_maint import mmu_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  csr_view_t             csr_i,
   input  tlb_cmd_e              tlb_cmd_i,
   input  logic                  tlb_rd_i,
   output logic                  wr_en_o,
   output logic [`MMU_IDX_W-1:0] wr_idx_o,
   output tlb_entry_t            wr_entry_o,
   output logic [`MMU_IDX_W-1:0] rd_idx_o,
   input  tlb_entry_t            rd_entry_i,
   output tlb_rd_rsp_t           tlb_rd_o
);

   logic [`MMU_IDX_W-1:0] fill_cnt_q;
   tlb_rd_rsp_t           rd_q;

   // free-running pseudo random refill slot
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fill_cnt_q <= '0;
      end else begin
         fill_cnt_q <= fill_cnt_q + 1'b1;
      end
   end

   assign wr_en_o  = (tlb_cmd_i == cmd_wr) || (tlb_cmd_i == cmd_fill);
   assign wr_idx_o = (tlb_cmd_i == cmd_fill) ? fill_cnt_q : csr_i.tlbidx;
   assign rd_idx_o = csr_i.tlbidx;

   always_comb begin
      wr_entry_o.exists = !csr_i.ne;                       // ne set writes an empty slot
      wr_entry_o.vppn   = csr_i.tlbehi_vppn;
      wr_entry_o.asid   = csr_i.asid;
      wr_entry_o.g      = csr_i.elo0_g && csr_i.elo1_g;
      wr_entry_o.lo0    = csr_i.elo0;
      wr_entry_o.lo1    = csr_i.elo1;
   end

   // read-back, a missing entry returns zeros
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_q.valid <= 1'b0;
      end else begin
         rd_q.valid <= tlb_rd_i;
         rd_q.entry <= rd_entry_i.exists ? rd_entry_i : '0;
      end
   end

   assign tlb_rd_o = rd_q;

endmodule

/* src/mmu_top.sv */
// mmu top: data-side translation, TLB storage and TLB maintenance
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_top import mmu_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  csr_view_t   csr_i,
   // translation pipe
   input  xlate_req_t  req_i,
   output xlate_rsp_t  rsp_o,
   // tlbwr / tlbfill / tlbrd
   input  tlb_cmd_e    tlb_cmd_i,
   input  logic        tlb_rd_i,
   output tlb_rd_rsp_t tlb_rd_o
);

   srch_req_t             srch_req;
   srch_rsp_t             srch_rsp;
   logic                  wr_en;
   logic [`MMU_IDX_W-1:0] wr_idx;
   tlb_entry_t            wr_entry;
   logic [`MMU_IDX_W-1:0] rd_idx;
   tlb_entry_t            rd_entry;

   tlb_array u_tlb (
      .clk        (clk),
      .rst_n      (rst_n),
      .srch_i     (srch_req),
      .srch_o     (srch_rsp),
      .wr_en_i    (wr_en),
      .wr_idx_i   (wr_idx),
      .wr_entry_i (wr_entry),
      .rd_idx_i   (rd_idx),
      .rd_entry_o (rd_entry)
   );

   addr_xlate u_xlate (
      .clk    (clk),
      .rst_n  (rst_n),
      .csr_i  (csr_i),
      .req_i  (req_i),
      .srch_o (srch_req),
      .srch_i (srch_rsp),
      .rsp_o  (rsp_o)
   );

   tlb_maint u_maint (
      .clk        (clk),
      .rst_n      (rst_n),
      .csr_i      (csr_i),
      .tlb_cmd_i  (tlb_cmd_i),
      .tlb_rd_i   (tlb_rd_i),
      .wr_en_o    (wr_en),
      .wr_idx_o   (wr_idx),
      .wr_entry_o (wr_entry),
      .rd_idx_o   (rd_idx),
      .rd_entry_i (rd_entry),
      .tlb_rd_o   (tlb_rd_o)
   );

endmodule

/* testbench/mmu_chk.sv */
// mmu checker for valid timing, reset state, exception-free ops and direct-mode address
`timescale 1ns/1ps

module mmu_chk import mmu_pkg::*; (
   input logic        clk,
   input logic        rst_n,
   input csr_view_t   csr_i,
   input xlate_req_t  req_i,
   input xlate_rsp_t  rsp_o,
   input logic        tlb_rd_i,
   input tlb_rd_rsp_t tlb_rd_o
);

   int fail_cnt = 0;   // read by the testbench at the end of the run

   // one result per request one cycle later
   rsp_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
      1'b1 |=> (rsp_o.valid == $past(req_i.valid)))
      else begin
         $error("rsp_o.valid does not follow req_i.valid");
         fail_cnt++;
      end

   rd_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
      1'b1 |=> (tlb_rd_o.valid == $past(tlb_rd_i)))
      else begin
         $error("tlb_rd_o.valid does not follow tlb_rd_i");
         fail_cnt++;
      end

   reset_a: assert property (@(posedge clk)
      !rst_n |=> (!rsp_o.valid && !tlb_rd_o.valid))
      else begin
         $error("valid output high right after reset");
         fail_cnt++;
      end

   // no request kind other than load and store can fault
   no_exc_a: assert property (@(posedge clk) disable iff (!rst_n)
      (req_i.valid && (req_i.op == op_none || req_i.op == op_tlbsrch))
      |=> (rsp_o.exc == exc_none))
      else begin
         $error("exception reported for op_none or op_tlbsrch");
         fail_cnt++;
      end

   direct_a: assert property (@(posedge clk) disable iff (!rst_n)
      (req_i.valid && csr_i.da) |=> (rsp_o.paddr == $past(req_i.vaddr)))
      else begin
         $error("direct mode paddr differs from vaddr");
         fail_cnt++;
      end

endmodule

bind mmu_top mmu_chk u_chk (.*);

/* testbench/tb_mmu.sv */
// mmu testbench driving direct, window and paged translation, TLB maintenance and read-back
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tb_mmu import mmu_pkg::*; ();

   logic                   clk;
   logic                   rst_n;
   csr_view_t              csr;
   xlate_req_t             req;
   xlate_rsp_t             rsp;
   tlb_cmd_e               cmd;
   logic                   rd;
   tlb_rd_rsp_t            rd_rsp;
   tlb_entry_t             mdl [`MMU_TLB_NUM];   // entries as written by the testbench
   xlate_rsp_t             exp_q [$];
   mem_op_e                op_q [$];
   string                  name_q [$];
   tlb_rd_rsp_t            rd_exp_q [$];
   logic [`MMU_IDX_W-1:0]  fill_slot;
   logic [`MMU_VPPN_W-1:0] vp [8];
   logic [31:0]            seed = 32'hf596_54ff;
   int                     val_err = 0;
   int                     tmo_err = 0;

   mmu_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .csr_i     (csr),
      .req_i     (req),
      .rsp_o     (rsp),
      .tlb_cmd_i (cmd),
      .tlb_rd_i  (rd),
      .tlb_rd_o  (rd_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // refill slot counter running from 0 after reset
   always @(posedge clk) begin
      if (!rst_n) fill_slot <= '0;
      else fill_slot <= fill_slot + 1'b1;
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic window_match(input dmw_t w, input logic [31:0] va);
      return ((w.plv0 && csr.plv == 2'd0) || (w.plv3 && csr.plv == 2'd3))
             && (w.vseg == va[31:29]);
   endfunction

   // expected result from the current csr view and the written entries
   function automatic xlate_rsp_t predict(input mem_op_e op, input logic [31:0] va);
      xlate_rsp_t             p;
      logic [`MMU_VPPN_W-1:0] vppn;
      tlb_lo_t                lo;
      p       = '0;
      p.valid = 1'b1;
      lo      = '0;
      vppn    = (op == op_tlbsrch) ? csr.tlbehi_vppn : va[31:13];
      for (int i = `MMU_TLB_NUM - 1; i >= 0; i--) begin   // downward so the lowest match stays
         if (mdl[i].exists && mdl[i].vppn == vppn && (mdl[i].g || mdl[i].asid == csr.asid)) begin
            p.found = 1'b1;
            p.index = i[`MMU_IDX_W-1:0];
            lo      = va[12] ? mdl[i].lo1 : mdl[i].lo0;
         end
      end
      if (csr.da) begin
         p.paddr    = va;
         p.uncached = (csr.datm == 2'd0);
      end else if (window_match(csr.dmw0, va)) begin
         p.paddr    = {csr.dmw0.pseg, va[28:0]};
         p.uncached = (csr.dmw0.mat == 2'd0);
      end else if (window_match(csr.dmw1, va)) begin
         p.paddr    = {csr.dmw1.pseg, va[28:0]};
         p.uncached = (csr.dmw1.mat == 2'd0);
      end else begin
         p.paddr    = {lo.ppn, va[11:0]};
         p.uncached = (lo.mat == 2'd0);
         if (op == op_load || op == op_store) begin
            if (csr.plv == 2'd3 && va[31]) p.exc = exc_adem;
            else if (!p.found) p.exc = exc_tlbr;
            else if (!lo.valid) p.exc = (op == op_load) ? exc_pil : exc_pis;
            else if (csr.plv > lo.plv) p.exc = exc_ppi;
            else if (op == op_store && !lo.dirty) p.exc = exc_pme;
         end
      end
      return p;
   endfunction

   task automatic issue(input mem_op_e op, input logic [31:0] va, input string name);
      req.valid = 1'b1;
      req.op    = op;
      req.vaddr = va;
      exp_q.push_back(predict(op, va));
      op_q.push_back(op);
      name_q.push_back(name);
      @(posedge clk);
      #2;
      req.valid = 1'b0;
   endtask

   task automatic tlb_write(input tlb_cmd_e c);
      logic [`MMU_IDX_W-1:0] idx;
      idx = (c == cmd_fill) ? fill_slot : csr.tlbidx;
      mdl[idx] = {!csr.ne, csr.tlbehi_vppn, csr.asid, csr.elo0_g & csr.elo1_g, csr.elo0, csr.elo1};
      cmd = c;
      @(posedge clk);
      #2;
      cmd = cmd_none;
   endtask

   task automatic tlb_read();
      tlb_rd_rsp_t e;
      e.valid = 1'b1;
      e.entry = mdl[csr.tlbidx].exists ? mdl[csr.tlbidx] : '0;
      rd_exp_q.push_back(e);
      rd = 1'b1;
      @(posedge clk);
      #2;
      rd = 1'b0;
   endtask

   // sampled at the falling edge where registered outputs are settled
   always @(negedge clk) begin : check
      xlate_rsp_t  e;
      xlate_rsp_t  care;
      tlb_rd_rsp_t re;
      mem_op_e     op;
      string       nm;
      if (rst_n && rsp.valid && exp_q.size() == 0) begin
         $display("translation result arrived with no request outstanding");
         val_err++;
      end else if (rst_n && rsp.valid) begin
         e    = exp_q.pop_front();
         op   = op_q.pop_front();
         nm   = name_q.pop_front();
         care = '1;
         if (op != op_tlbsrch) begin   // found and index only defined for tlbsrch
            care.found = 1'b0;
            care.index = '0;
         end
         if (e.exc != exc_none || op == op_none || op == op_tlbsrch) begin   // paddr undefined
            care.paddr    = '0;
            care.uncached = 1'b0;
         end
         assert (((rsp ^ e) & care) === '0) else begin
            $display("** Error %s: expected %h, actual %h", nm, e, rsp);
            val_err++;
         end
      end
      if (rst_n && rd_rsp.valid && rd_exp_q.size() == 0) begin
         $display("TLB read data arrived with no read outstanding");
         val_err++;
      end else if (rst_n && rd_rsp.valid) begin
         re = rd_exp_q.pop_front();
         assert (rd_rsp === re) else begin
            $display("** Error tlb read-back: expected %h, actual %h", re, rd_rsp);
            val_err++;
         end
      end
   end

   initial begin
      logic [31:0] r;
      int          k;
      rst_n = 1'b0;
      csr   = '0;
      req   = '0;
      cmd   = cmd_none;
      rd    = 1'b0;
      for (int i = 0; i < `MMU_TLB_NUM; i++)
         mdl[i] = '0;
      repeat (8) @(posedge clk);
      #2 rst_n = 1'b1;

      csr.da = 1'b1;
      for (int i = 0; i < 8; i++) begin
         r = lcg_next();
         csr.datm = r[31:30];
         issue(mem_op_e'(r[29:28]), lcg_next(), "direct");
      end

      // dmw0 for plv0 only and dmw1 for both levels
      csr.da   = 1'b0;
      csr.dmw0 = {1'b1, 1'b0, 2'd1, 3'h1, 3'h4};
      csr.dmw1 = {1'b1, 1'b1, 2'd0, 3'h6, 3'h5};
      for (int i = 0; i < 4; i++) begin
         r = lcg_next();
         issue(op_load, {3'h4, r[28:0]}, "dmw0 hit");
         issue(op_store, {3'h5, r[31:3]}, "dmw1 hit");
      end
      csr.dmw1.vseg = 3'h4;
      issue(op_load, {3'h4, r[28:0]}, "dmw0 over dmw1");
      csr.dmw1.vseg = 3'h5;
      csr.plv       = 2'd3;
      issue(op_load, {3'h4, r[28:0]}, "dmw0 disabled at plv3");
      issue(op_load, {3'h5, r[28:0]}, "dmw1 at plv3");
      csr.dmw0 = '0;
      csr.dmw1 = '0;
      csr.plv  = 2'd0;

      csr.asid = 10'h155;
      for (int i = 0; i < 8; i++) begin
         r = lcg_next();
         vp[i]           = {i[3:0], r[31:17]};
         csr.tlbidx      = i[3:0];
         csr.tlbehi_vppn = vp[i];
         csr.elo0        = {2'b11, r[29:6]};
         r = lcg_next();
         csr.elo1        = {1'b1, r[30:6]};
         csr.elo0_g      = (i == 3) || (i == 5);
         csr.elo1_g      = (i == 3) || (i == 6);
         tlb_write(cmd_wr);
      end
      for (int i = 0; i < 8; i++) begin
         r = lcg_next();
         csr.tlbehi_vppn = vp[i];
         issue(op_load, {vp[i], 1'b0, r[31:20]}, "paged even");
         issue(op_store, {vp[i], 1'b1, r[19:8]}, "paged odd");
         issue(op_tlbsrch, r, "tlbsrch hit");
      end
      csr.tlbehi_vppn = {4'hf, r[14:0]};
      issue(op_tlbsrch, r, "tlbsrch miss");
      issue(op_load, {4'hf, r[27:0]}, "unwritten page");
      csr.asid = 10'h2aa;
      issue(op_load, {vp[2], r[12:0]}, "asid mismatch");
      issue(op_load, {vp[3], r[12:0]}, "global entry");
      issue(op_store, {vp[5], r[12:0]}, "one global bit");
      csr.asid = 10'h155;

      // slot 10 gets an invalid even half and a valid clean odd half
      r = lcg_next();
      csr.tlbidx      = 4'd10;
      csr.tlbehi_vppn = {4'h2, r[14:0]};
      csr.elo0        = {6'b00_00_01, r[31:12]};
      csr.elo1        = {6'b10_00_00, r[19:0]};
      tlb_write(cmd_wr);
      issue(op_load, {csr.tlbehi_vppn, 1'b1, r[11:0]}, "odd half uncached");
      issue(op_load, {4'he, r[27:0]}, "exc tlbr");
      issue(op_load, {csr.tlbehi_vppn, 1'b0, r[11:0]}, "exc pil");
      issue(op_store, {csr.tlbehi_vppn, 1'b0, r[11:0]}, "exc pis");
      issue(op_store, {csr.tlbehi_vppn, 1'b1, r[11:0]}, "exc pme");
      csr.plv = 2'd3;
      issue(op_load, {1'b1, r[30:0]}, "exc adem over tlbr");
      issue(op_load, {csr.tlbehi_vppn, 1'b1, r[11:0]}, "exc ppi");
      issue(op_store, {csr.tlbehi_vppn, 1'b0, r[11:0]}, "exc pis over ppi");
      csr.plv = 2'd0;

      r = lcg_next();
      csr.tlbehi_vppn = {4'h9, r[14:0]};
      csr.elo0        = {6'b11_00_11, r[31:12]};
      csr.elo1        = {6'b11_00_10, r[19:0]};
      tlb_write(cmd_fill);
      issue(op_load, {4'h9, r[14:0], 1'b0, r[11:0]}, "filled even");
      issue(op_store, {4'h9, r[14:0], 1'b1, r[11:0]}, "filled odd");
      for (int i = 3; i < 7; i++) begin
         csr.tlbidx = i[3:0];
         tlb_read();
      end
      csr.tlbidx      = 4'd2;
      csr.tlbehi_vppn = vp[2];
      csr.ne          = 1'b1;   // slot 2 becomes empty
      tlb_write(cmd_wr);
      csr.ne = 1'b0;
      issue(op_load, {vp[2], r[12:0]}, "removed entry");
      tlb_read();

      // back-to-back mixed traffic
      for (int i = 0; i < 16; i++) begin
         r = lcg_next();
         issue(mem_op_e'(r[31:30]), {vp[r[29:27]], r[12:0]}, "burst");
      end

      k = 0;
      while ((exp_q.size() != 0 || rd_exp_q.size() != 0) && k < 20) begin
         @(posedge clk);
         k++;
      end
      if (exp_q.size() != 0 || rd_exp_q.size() != 0) begin
         $display("timeout while waiting for outstanding results");
         tmo_err++;
      end
      $display("value errors: %0d, timeouts: %0d, assertion errors: %0d",
               val_err, tmo_err, u_dut.u_chk.fail_cnt);
      if (val_err == 0 && tmo_err == 0 && u_dut.u_chk.fail_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+src
src/mmu_pkg.sv
src/tlb_array.sv
src/addr_xlate.sv
src/tlb_maint.sv
src/mmu_top.sv
testbench/mmu_chk.sv
testbench/tb_mmu.sv

/* Bender.yml */
package:
  name: mmu

sources:
  - include_dirs:
      - src
    files:
      - src/mmu_pkg.sv
      - src/tlb_array.sv
      - src/addr_xlate.sv
      - src/tlb_maint.sv
      - src/mmu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/mmu_chk.sv
      - testbench/tb_mmu.sv
